/* build.f */
+incdir+include
src/apple1_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/char_fifo.sv
src/pia.sv
src/apple1_top.sv
test/apple1_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the apple 1 terminal testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f build.f --top-module apple1_tb -o apple1_sim
out=$(./obj_dir/apple1_sim)
echo "$out"
if echo "$out" | grep -qx "sim passed"; then
  exit 0
fi
exit 1

/* test/apple1_tb.sv */
//######################################################################
// testbench for the apple 1 terminal side
// cpu bus and host serial models, uart_tx monitor and comparator
// reference functions, compare tasks, cycle limit
//######################################################################

`timescale 1ns/1ps
`include "apple1_settings.svh"

module apple1_tb;

  localparam int BIT_CYCLES  = `APPLE1_BIT_CYCLES;
  localparam int CYCLE_LIMIT = 250000;  // ~40 frames of 2170 cycles, plus margin

  logic                 clk = 1'b0;
  logic                 reset = 1'b1;
  apple1_pkg::cpu_bus_t bus;
  logic                 uart_rx;
  logic [7:0]           bus_rdata;
  logic                 uart_tx;
  logic                 uart_cts;

  integer     seed = 32'h7d87_dad9;
  int         errors = 0;      // bus side mismatches
  int         tx_errors = 0;   // serial output mismatches
  int         tx_checked = 0;
  int         cycles = 0;
  logic [7:0] exp_tx[$];       // expected serial bytes, in write order
  logic [7:0] tx_seen[$];      // decoded off uart_tx

  apple1_top dut (.clk25(clk), .reset(reset), .bus(bus), .uart_rx(uart_rx),
                  .bus_rdata(bus_rdata), .uart_tx(uart_tx), .uart_cts(uart_cts));

  // keyboard value: a..z lose bit 5, bit 7 always set
  function automatic logic [7:0] ref_key(input logic [7:0] c);
    logic [7:0] k;
    k = c;
    if (c inside {[8'h61:8'h7a]}) k[5] = 1'b0;
    k[7] = 1'b1;
    return k;
  endfunction

  // only the low 7 bits of a display write reach the line
  function automatic logic [7:0] ref_tx(input logic [7:0] w);
    return {1'b0, w[6:0]};
  endfunction

  // printable ascii, every third one forced to lower case
  function automatic logic [7:0] rand_char(input int i);
    int unsigned r;
    r = $unsigned($random(seed));
    return (i % 3 == 0) ? 8'(8'h61 + r % 26) : 8'(8'h20 + r % 95);
  endfunction

  task automatic check_key(input string name, input logic [7:0] exp, input logic [7:0] got);
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t %s expected %02h got %02h", $time, name, exp, got);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t %s expected %0b got %0b", $time, name, exp, got);
    end
  endtask

  task automatic check_tx(input logic [7:0] exp, input logic [7:0] got);
    if (got !== exp) begin
      tx_errors++;
      $display("FAIL t=%0t uart_tx expected %02h got %02h", $time, exp, got);
    end
  endtask

  // single bus cycles, entered 1 ns after an edge and left the same way
  task automatic bus_write(input apple1_pkg::pia_reg_e sel, input logic [7:0] data);
    bus = '{cs: 1'b1, we: 1'b1, reg_sel: sel, wdata: data};
    @(posedge clk);
    #1 bus = '0;
  endtask

  task automatic bus_read(input apple1_pkg::pia_reg_e sel, output logic [7:0] data);
    bus = '{cs: 1'b1, we: 1'b0, reg_sel: sel, wdata: 8'h00};
    @(posedge clk);
    #1 bus = '0;
    data = bus_rdata;  // registered at the edge just passed
  endtask

  // host 8N1 frame, waits for cts before the start bit
  // a bad stop stays low just past mid-stop so no new start is seen
  task automatic send_frame(input logic [7:0] c, input logic stop_ok);
    while (!uart_cts) begin
      @(posedge clk);
      #1;
    end
    uart_rx = 1'b0;
    repeat (BIT_CYCLES) @(posedge clk);
    for (int b = 0; b < 8; b++) begin
      #1 uart_rx = c[b];  // lsb first
      repeat (BIT_CYCLES) @(posedge clk);
    end
    #1 uart_rx = stop_ok;
    repeat (stop_ok ? BIT_CYCLES : BIT_CYCLES * 3 / 4) @(posedge clk);
    #1 uart_rx = 1'b1;
  endtask

  task automatic wait_key(output logic [7:0] key);
    logic [7:0] st;
    st = 8'h00;
    while (!st[7]) bus_read(apple1_pkg::KBDCR, st);  // key available
    bus_read(apple1_pkg::KBD, key);
  endtask

  task automatic wait_dsp_idle();
    logic [7:0] st;
    st = 8'h80;
    while (st[7]) bus_read(apple1_pkg::DSP, st);  // display busy
  endtask

  initial begin
    forever #20 clk = ~clk;
  end

  // decode uart_tx at mid-bit, on the falling clock so txd is settled
  initial begin : tx_monitor
    logic [7:0] b;
    wait (!reset);
    forever begin
      @(negedge clk);
      if (uart_tx === 1'b0) begin
        repeat (BIT_CYCLES / 2) @(negedge clk);  // mid start
        for (int i = 0; i < 8; i++) begin
          repeat (BIT_CYCLES) @(negedge clk);
          b[i] = uart_tx;
        end
        repeat (BIT_CYCLES) @(negedge clk);
        if (uart_tx !== 1'b1) begin
          tx_errors++;
          $display("uart_tx stop bit low at t=%0t, frame dropped", $time);
        end else begin
          tx_seen.push_back(b);
        end
      end
    end
  end

  // every decoded byte against the next expected one
  initial begin : tx_compare
    logic [7:0] got;
    forever begin
      @(posedge clk);
      if (tx_seen.size() != 0) begin
        got = tx_seen.pop_front();
        if (exp_tx.size() == 0) begin
          tx_errors++;
          $display("uart_tx sent %02h at t=%0t with no display write behind it", got, $time);
        end else begin
          check_tx(exp_tx.pop_front(), got);
          tx_checked++;
        end
      end
    end
  end

  initial begin : watchdog
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run still going after %0d cycles", CYCLE_LIMIT);
    $display("errors: %0d bus, %0d tx, %0d tx bytes compared", errors, tx_errors, tx_checked);
    $display("sim failed");
    $finish;
  end

  initial begin : stimulus
    logic [7:0] c;
    logic [7:0] d;
    logic [7:0] sent[$];
    bus = '0;
    uart_rx = 1'b1;  // line idles at mark
    repeat (2) @(posedge clk);
    #1 reset = 1'b0;
    bus_read(apple1_pkg::KBDCR, d);
    check_flag("KBDCR[7]", 1'b0, d[7]);
    bus_read(apple1_pkg::DSP, d);
    check_flag("DSP[7]", 1'b0, d[7]);
    check_flag("uart_tx", 1'b1, uart_tx);
    check_flag("uart_cts", 1'b1, uart_cts);
    for (int i = 0; i < 20; i++) begin  // one key at a time
      c = rand_char(i);
      send_frame(c, 1'b1);
      wait_key(d);
      check_key("KBD", ref_key(c), d);
      bus_read(apple1_pkg::KBDCR, d);
      check_flag("KBDCR[7]", 1'b0, d[7]);  // released by the read
    end
    for (int i = 0; i < 6; i++) begin  // display bytes, bit 7 may be set
      c = 8'($random(seed));
      wait_dsp_idle();
      exp_tx.push_back(ref_tx(c));
      bus_write(apple1_pkg::DSP, c);
      bus_read(apple1_pkg::DSP, d);
      check_flag("DSP[7]", 1'b1, d[7]);
    end
    wait_dsp_idle();
    exp_tx.push_back(ref_tx(8'h41));
    bus_write(apple1_pkg::DSP, 8'h41);
    bus_write(apple1_pkg::DSP, 8'h42);  // lands while busy, must vanish
    while (exp_tx.size() != 0) @(posedge clk);
    repeat (20 * BIT_CYCLES) @(posedge clk);  // room for a stray frame
    #1;
    for (int i = 0; i < `APPLE1_CTS_LEVEL + 1; i++) begin  // first one sits in KBD
      sent.push_back(rand_char(i));
      send_frame(sent[i], 1'b1);
    end
    repeat (4) @(posedge clk);
    #1 check_flag("uart_cts", 1'b0, uart_cts);
    foreach (sent[i]) begin
      wait_key(d);
      check_key("KBD", ref_key(sent[i]), d);
    end
    check_flag("uart_cts", 1'b1, uart_cts);
    send_frame(8'h51, 1'b0);  // framing error, dropped at the queue
    repeat (2 * BIT_CYCLES) @(posedge clk);
    #1 bus_read(apple1_pkg::KBDCR, d);
    check_flag("KBDCR[7]", 1'b0, d[7]);
    send_frame(8'h6b, 1'b1);
    wait_key(d);
    check_key("KBD", ref_key(8'h6b), d);
    if (exp_tx.size() != 0) begin
      errors++;
      $display("%0d display bytes never showed up on uart_tx", exp_tx.size());
    end
    $display("errors: %0d bus, %0d tx, %0d tx bytes compared", errors, tx_errors, tx_checked);
    if (errors == 0 && tx_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* src/apple1_top.sv */
//####################################################################
// board top level for the apple 1 terminal side
// serial rx -> char queue -> pia keyboard register
// pia display register -> serial tx, cts out to the host
//####################################################################

`timescale 1ns/1ps

module apple1_top (
  input  logic                 clk25,      // 25 MHz board clock
  input  logic                 reset,
  input  apple1_pkg::cpu_bus_t bus,        // 6502 side peripheral bus
  input  logic                 uart_rx,    // serial data from the host
  output logic [7:0]           bus_rdata,
  output logic                 uart_tx,    // serial data to the host
  output logic                 uart_cts    // clear to send toward the host
);

  logic                 rx_valid;
  apple1_pkg::rx_char_t rx_char;
  apple1_pkg::rx_char_t fifo_head;
  logic                 fifo_not_empty;
  logic                 key_pop;
  logic                 tx_send;
  logic [7:0]           tx_data;
  logic                 tx_ready;

  // host serial in
  uart_rx rx_inst (
    .clk25    (clk25),
    .reset    (reset),
    .rxd      (uart_rx),
    .rx_valid (rx_valid),
    .rx_char  (rx_char)
  );

  // typed-ahead keys wait here, cts straight to the pin
  char_fifo fifo_inst (
    .clk25     (clk25),
    .reset     (reset),
    .push      (rx_valid),
    .push_char (rx_char),
    .pop       (key_pop),
    .head      (fifo_head),
    .not_empty (fifo_not_empty),
    .cts       (uart_cts)
  );

  pia pia_inst (
    .clk25     (clk25),
    .reset     (reset),
    .bus       (bus),
    .key_valid (fifo_not_empty),
    .key_char  (fifo_head),
    .tx_ready  (tx_ready),
    .bus_rdata (bus_rdata),
    .key_pop   (key_pop),
    .tx_send   (tx_send),
    .tx_data   (tx_data)
  );

  // display output back to the host terminal
  uart_tx tx_inst (
    .clk25    (clk25),
    .reset    (reset),
    .tx_send  (tx_send),
    .tx_data  (tx_data),
    .tx_ready (tx_ready),
    .txd      (uart_tx)
  );

endmodule

/* src/pia.sv */
//####################################################################
// apple 1 peripheral registers at D010..D013
// keyboard register with case folding and key available flag
// display register with busy flag toward the transmitter
//####################################################################

`timescale 1ns/1ps

module pia (
  input  logic                 clk25,
  input  logic                 reset,
  input  apple1_pkg::cpu_bus_t bus,
  input  logic                 key_valid,
  input  apple1_pkg::rx_char_t key_char,
  input  logic                 tx_ready,
  output logic [7:0]           bus_rdata,
  output logic                 key_pop,
  output logic                 tx_send,
  output logic [7:0]           tx_data
);

  logic [7:0] key_reg;    // bit 7 always set once loaded
  logic       key_avail;  // KBDCR bit 7
  logic [6:0] dsp_data;   // only 7 bits reach the display
  logic       busy;       // DSP bit 7
  logic       bus_rd;
  logic       bus_wr;
  logic       kbd_rd;
  logic       dsp_wr;

  // the monitor only knows upper case
  function automatic logic [7:0] fold_upper(input logic [7:0] c);
    logic [7:0] r;
    r = c;
    if (c >= 8'h61 && c <= 8'h7a) r = c - 8'h20;  // a..z
    return r;
  endfunction

  assign bus_rd = bus.cs && !bus.we;
  assign bus_wr = bus.cs && bus.we;
  assign kbd_rd = bus_rd && (bus.reg_sel == apple1_pkg::KBD);
  assign dsp_wr = bus_wr && (bus.reg_sel == apple1_pkg::DSP) && !busy;  // busy drops it

  // pull the queue head whenever the keyboard register is free
  assign key_pop = key_valid && !key_avail;

  // byte goes out the cycle the transmitter can take it
  assign tx_send = busy && tx_ready;
  assign tx_data = {1'b0, dsp_data};

  // keyboard side
  always_ff @(posedge clk25) begin
    if (reset) begin
      key_avail <= 1'b0;
    end else begin
      if (kbd_rd) key_avail <= 1'b0;  // reading KBD releases the key
      if (key_pop) key_avail <= 1'b1;  // only when empty, so no clash with read
    end
  end

  always_ff @(posedge clk25) begin
    if (key_pop) key_reg <= fold_upper(key_char.data) | 8'h80;
  end

  // display side
  always_ff @(posedge clk25) begin
    if (reset) begin
      busy <= 1'b0;
    end else if (dsp_wr) begin
      busy <= 1'b1;
    end else if (tx_send) begin
      busy <= 1'b0;  // cleared on accept, not at end of frame
    end
  end

  always_ff @(posedge clk25) begin
    if (dsp_wr) dsp_data <= bus.wdata[6:0];
  end

  // read mux, data shows next cycle and holds until the next read
  // writes to KBDCR and DSPCR land nowhere
  always_ff @(posedge clk25) begin
    if (bus_rd) begin
      case (bus.reg_sel)
        apple1_pkg::KBD:   bus_rdata <= key_reg;
        apple1_pkg::KBDCR: bus_rdata <= {key_avail, 7'b0};
        apple1_pkg::DSP:   bus_rdata <= {busy, 7'b0};
        apple1_pkg::DSPCR: bus_rdata <= 8'h00;
        default:           bus_rdata <= 8'h00;
      endcase
    end
  end

  // transmitter leaves idle right after each send it is handed
  a_send_taken: assert property (@(posedge clk25) disable iff (reset)
    tx_send |=> !tx_ready)
    else $error("pia tx_send not taken by the transmitter");

endmodule

/* src/char_fifo.sv */
//####################################################################
// receive character queue
// circular buffer with fill count, framing errors dropped on entry
// clear-to-send from the fill level
//####################################################################

`timescale 1ns/1ps
`include "apple1_settings.svh"

module char_fifo (
  input  logic                 clk25,
  input  logic                 reset,
  input  logic                 push,
  input  apple1_pkg::rx_char_t push_char,
  input  logic                 pop,
  output apple1_pkg::rx_char_t head,
  output logic                 not_empty,
  output logic                 cts
);

  localparam int DEPTH = `APPLE1_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  apple1_pkg::rx_char_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;   // entries held
  logic             full;
  logic             do_push;
  logic             do_pop;

  assign full      = (count == CNT_W'(DEPTH));
  assign not_empty = (count != '0);
  assign do_push   = push && !push_char.frame_err && !full;  // bad frames never queue
  assign do_pop    = pop && not_empty;
  assign head      = mem[rd_ptr];
  assign cts       = (count < CNT_W'(`APPLE1_CTS_LEVEL));  // host pauses near full

  always_ff @(posedge clk25) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  always_ff @(posedge clk25) begin
    if (do_push) mem[wr_ptr] <= push_char;
  end

  // host is expected to honor cts, so a full queue never sees a char
  a_no_overflow: assert property (@(posedge clk25) disable iff (reset)
    (push && !push_char.frame_err) |-> !full)
    else $error("char_fifo push into full queue, char lost");

  a_no_underflow: assert property (@(posedge clk25) disable iff (reset)
    pop |-> not_empty)
    else $error("char_fifo pop while empty");

endmodule

/* src/uart_tx.sv */
//####################################################################
// 8N1 serial transmitter
// one byte accepted while idle, then start, 8 data lsb first, stop
//####################################################################

`timescale 1ns/1ps
`include "apple1_settings.svh"

module uart_tx (
  input  logic       clk25,
  input  logic       reset,
  input  logic       tx_send,
  input  logic [7:0] tx_data,
  output logic       tx_ready,
  output logic       txd
);

  localparam int BIT_CYCLES = `APPLE1_BIT_CYCLES;
  localparam int CNT_W      = $clog2(BIT_CYCLES);

  apple1_pkg::uart_state_e state;

  logic [CNT_W-1:0] cnt;      // clocks within the current bit
  logic [2:0]       bit_idx;  // data bits already on the line
  logic [7:0]       shreg;    // current bit sits in shreg[0]
  logic             bit_end;

  assign bit_end  = (cnt == CNT_W'(BIT_CYCLES - 1));
  assign tx_ready = (state == apple1_pkg::IDLE);  // accept only between frames

  always_ff @(posedge clk25) begin
    if (reset) begin
      state   <= apple1_pkg::IDLE;
      cnt     <= '0;
      bit_idx <= '0;
      txd     <= 1'b1;  // mark
    end else begin
      cnt <= cnt + 1'b1;
      case (state)
        apple1_pkg::IDLE: begin
          cnt <= '0;
          txd <= 1'b1;
          if (tx_send) begin
            state <= apple1_pkg::START;
            txd   <= 1'b0;  // start bit goes out right away
          end
        end
        apple1_pkg::START: begin
          if (bit_end) begin
            cnt     <= '0;
            bit_idx <= '0;
            txd     <= shreg[0];
            state   <= apple1_pkg::DATA;
          end
        end
        apple1_pkg::DATA: begin
          if (bit_end) begin
            cnt     <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              txd   <= 1'b1;  // stop bit
              state <= apple1_pkg::STOP;
            end else begin
              txd <= shreg[1];  // next bit, shreg shifts below
            end
          end
        end
        apple1_pkg::STOP: if (bit_end) state <= apple1_pkg::IDLE;
        default: state <= apple1_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk25) begin
    if (tx_ready && tx_send) shreg <= tx_data;
    else if (state == apple1_pkg::DATA && bit_end) shreg <= {1'b0, shreg[7:1]};
  end

  // the display side must wait for ready before sending
  a_send_when_ready: assert property (@(posedge clk25) disable iff (reset)
    tx_send |-> tx_ready)
    else $error("uart_tx got tx_send while busy");

endmodule

/* src/uart_rx.sv */
//####################################################################
// 8N1 serial receiver
// two-flop input sync, start bit check at mid-bit
// lsb first sampling, stop bit framing flag
//####################################################################

`timescale 1ns/1ps
`include "apple1_settings.svh"

module uart_rx (
  input  logic                 clk25,
  input  logic                 reset,
  input  logic                 rxd,
  output logic                 rx_valid,
  output apple1_pkg::rx_char_t rx_char
);

  localparam int BIT_CYCLES = `APPLE1_BIT_CYCLES;
  localparam int HALF_BIT   = BIT_CYCLES / 2;
  localparam int CNT_W      = $clog2(BIT_CYCLES);

  apple1_pkg::uart_state_e state;

  logic             rxd_meta;   // first sync stage
  logic             rxd_sync;   // line as seen by the fsm
  logic [CNT_W-1:0] cnt;        // clocks within the current bit
  logic [2:0]       bit_idx;    // data bit number
  logic [7:0]       shreg;      // data bits shift in at the top
  logic             bit_end;
  logic             mid_start;

  assign bit_end   = (cnt == CNT_W'(BIT_CYCLES - 1));
  assign mid_start = (cnt == CNT_W'(HALF_BIT - 1));

  // line idles high, so sync comes out of reset high
  always_ff @(posedge clk25) begin
    if (reset) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
    end
  end

  always_ff @(posedge clk25) begin
    if (reset) begin
      state    <= apple1_pkg::IDLE;
      cnt      <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;  // single cycle pulse
      cnt      <= cnt + 1'b1;
      case (state)
        apple1_pkg::IDLE: begin
          cnt <= '0;
          if (!rxd_sync) state <= apple1_pkg::START;  // falling edge
        end
        apple1_pkg::START: begin
          if (mid_start) begin
            cnt     <= '0;  // from here on count whole bits, mid to mid
            bit_idx <= '0;
            if (rxd_sync) begin
              state <= apple1_pkg::IDLE;  // glitch, not a start bit
            end else begin
              state <= apple1_pkg::DATA;
            end
          end
        end
        apple1_pkg::DATA: begin
          if (bit_end) begin
            cnt     <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) state <= apple1_pkg::STOP;
          end
        end
        apple1_pkg::STOP: begin
          if (bit_end) begin
            state    <= apple1_pkg::IDLE;
            rx_valid <= 1'b1;  // char valid the cycle after mid-stop
          end
        end
        default: state <= apple1_pkg::IDLE;
      endcase
    end
  end

  // data path
  always_ff @(posedge clk25) begin
    if (state == apple1_pkg::DATA && bit_end) shreg <= {rxd_sync, shreg[7:1]};
    if (state == apple1_pkg::STOP && bit_end) begin
      rx_char.data      <= shreg;
      rx_char.frame_err <= ~rxd_sync;  // stop must be high
    end
  end

  // every reported char had its start bit confirmed low at mid-start, nine bits back
  a_start_taken: assert property (@(posedge clk25) disable iff (reset)
    rx_valid |->
      $past(state == apple1_pkg::START && mid_start && !rxd_sync, 9 * BIT_CYCLES + 1))
    else $error("uart_rx char reported without a confirmed start bit");

endmodule

/* src/apple1_pkg.sv */
//####################################################################
// shared types for the apple 1 terminal side
// cpu bus cycle, pia register select, uart states
// received character word
//####################################################################

package apple1_pkg;

  // pia register offsets, D010..D013
  typedef enum logic [1:0] {
    KBD   = 2'd0,  // keyboard data
    KBDCR = 2'd1,  // keyboard control, bit 7 = key available
    DSP   = 2'd2,  // display data, bit 7 = busy
    DSPCR = 2'd3   // display control
  } pia_reg_e;

  // one cpu bus cycle, valid for a single clock with cs high
  typedef struct packed {
    logic       cs;       // chip select
    logic       we;       // write enable
    pia_reg_e   reg_sel;  // register offset
    logic [7:0] wdata;    // write data
  } cpu_bus_t;

  // serial frame states, shared by rx and tx
  typedef enum logic [1:0] {
    IDLE,
    START,
    DATA,
    STOP
  } uart_state_e;

  // one character off the serial line
  typedef struct packed {
    logic [7:0] data;
    logic       frame_err;  // stop bit sampled low
  } rx_char_t;

endpackage

/* include/apple1_settings.svh */
//####################################################################
// clock and serial rate for the terminal side
// receive queue depth and clear-to-send threshold
//####################################################################

`ifndef APPLE1_SETTINGS_SVH
`define APPLE1_SETTINGS_SVH

// board clock, enters without a pll
`define APPLE1_CLK_HZ 25000000

// host serial line, 8N1
`define APPLE1_BAUD 115200

// clocks per serial bit, 217 at 25 MHz
`define APPLE1_BIT_CYCLES (`APPLE1_CLK_HZ / `APPLE1_BAUD)

// receive queue entries
`define APPLE1_FIFO_DEPTH 8

// fill level where cts to the host drops
`define APPLE1_CTS_LEVEL 6

`endif
